//--- files.f
common/chiplet_pkg.sv
hw/endpoint/endpoint_regs.sv
hw/endpoint/endpoint_tx.sv
hw/endpoint/endpoint_rx.sv
hw/switch/switch_core.sv
hw/switch_endpoint_top.sv
dv/tb_switch_endpoint.sv

//--- Bender.yml
package:
  name: chiplet_node

sources:
  - common/chiplet_pkg.sv
  - hw/endpoint/endpoint_regs.sv
  - hw/endpoint/endpoint_tx.sv
  - hw/endpoint/endpoint_rx.sv
  - hw/switch/switch_core.sv
  - hw/switch_endpoint_top.sv
  - target: test
    files:
      - dv/tb_switch_endpoint.sv

//--- dv/tb_switch_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module tb_switch_endpoint;
    localparam int loop_packets = 3;
    localparam int out_packets = 6;
    localparam int in_packets = 3;
    localparam int pass_packets = 4;
    // the error section sends one packet and pass-through runs two streams
    localparam int total_packets = 1 + loop_packets + out_packets + in_packets + 2 * pass_packets;
    localparam int timeout_cycles = total_packets * 64 + 500;
    localparam int words_width = chiplet_pkg::max_words * chiplet_pkg::data_width;
    localparam logic [31:0] lfsr_seed = 32'h92e5e8e5;

    logic clk;
    logic arst_n;
    logic wen;
    logic ren;
    logic [chiplet_pkg::addr_width-1:0] addr;
    logic [chiplet_pkg::data_width-1:0] wdata;
    logic [chiplet_pkg::strobe_width-1:0] strobe;
    logic [chiplet_pkg::data_width-1:0] rdata;
    logic error;
    logic request_stall;
    chiplet_pkg::flit_t in_flit;
    logic in_valid;
    logic data_ready_in;
    chiplet_pkg::flit_t out_flit;
    logic data_ready_out;
    logic packet_sent;

    logic [31:0] lfsr_state;
    logic [31:0] bp_state; // separate stream for back-pressure
    chiplet_pkg::flit_t exp_local [$]; // flits from this node's endpoint
    chiplet_pkg::flit_t exp_ext [$]; // pass-through flits
    chiplet_pkg::flit_t mon_exp;
    int mon_left;
    logic mon_from_ext;
    int cycles;
    int last_stalls;

    logic [chiplet_pkg::node_width-1:0] ext_src [pass_packets];
    logic [chiplet_pkg::node_width-1:0] ext_dest [pass_packets];
    logic [chiplet_pkg::count_width-1:0] ext_len [pass_packets];
    logic [words_width-1:0] ext_words [pass_packets];

    switch_endpoint_top switch_endpoint_top_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wen(wen),
        .ren(ren),
        .addr(addr),
        .wdata(wdata),
        .strobe(strobe),
        .rdata(rdata),
        .error(error),
        .request_stall(request_stall),
        .in_flit(in_flit),
        .in_valid(in_valid),
        .data_ready_in(data_ready_in),
        .out_flit(out_flit),
        .data_ready_out(data_ready_out),
        .packet_sent(packet_sent)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [chiplet_pkg::node_width-1:0] other_node();
        logic [chiplet_pkg::node_width-1:0] n;
        n = chiplet_pkg::node_width'(rand_bits(chiplet_pkg::node_width));
        if (n == chiplet_pkg::node_id) begin
            n = n ^ 2'b10;
        end
        return n;
    endfunction

    function automatic chiplet_pkg::flit_t head_flit(input logic [1:0] src, input logic [1:0] dest,
                                                     input logic [2:0] len);
        chiplet_pkg::flit_t f;
        f = '0;
        f.kind = chiplet_pkg::head;
        f.payload.head.dest = dest;
        f.payload.head.source = src;
        f.payload.head.length = len;
        return f;
    endfunction

    function automatic chiplet_pkg::flit_t data_flit(input logic [31:0] word);
        chiplet_pkg::flit_t f;
        f.kind = chiplet_pkg::data;
        f.payload.word = word;
        return f;
    endfunction

    // reference packet with the head first and the data words in push order
    function automatic void expect_packet(input logic [1:0] src, input logic [1:0] dest,
                                          input logic [2:0] len, input logic [words_width-1:0] words);
        chiplet_pkg::flit_t f;
        for (int i = 0; i <= int'(len); i++) begin
            if (i == 0) begin
                f = head_flit(src, dest, len);
            end else begin
                f = data_flit(words[(i-1)*chiplet_pkg::data_width +: chiplet_pkg::data_width]);
            end
            if (src == chiplet_pkg::node_id) begin
                exp_local.push_back(f);
            end else begin
                exp_ext.push_back(f);
            end
        end
    endfunction

    function automatic logic [31:0] status_word(input logic [2:0] txc, input logic txb,
                                                input logic [2:0] rxc, input logic rxv,
                                                input logic [1:0] rxs);
        logic [31:0] s;
        s = '0;
        s[2:0] = txc;
        s[3] = txb;
        s[6:4] = rxc;
        s[7] = rxv;
        s[9:8] = rxs;
        return s;
    endfunction

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_flit(input string name, input chiplet_pkg::flit_t exp,
                              input chiplet_pkg::flit_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [chiplet_pkg::data_width-1:0] exp,
                              input logic [chiplet_pkg::data_width-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_error(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // one bus access held until request_stall drops
    task automatic bus_access(input logic write, input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, output logic [31:0] rd, output logic err);
        wen = write;
        ren = !write;
        addr = a;
        wdata = d;
        strobe = s;
        last_stalls = 0;
        @(negedge clk);
        while (request_stall) begin
            last_stalls++;
            @(negedge clk);
        end
        rd = rdata;
        err = error;
        @(posedge clk);
        #1;
        wen = 1'b0;
        ren = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                             input logic exp_err);
        logic [31:0] rd;
        logic err;
        bus_access(1'b1, a, d, s, rd, err);
        check_error("error", exp_err, err);
    endtask

    task automatic read_reg(input logic [31:0] a, input logic exp_err, output logic [31:0] d);
        logic err;
        bus_access(1'b0, a, '0, '0, d, err);
        check_error("error", exp_err, err);
    endtask

    task automatic random_packet(output logic [2:0] len, output logic [words_width-1:0] words);
        len = 3'(rand_bits(2) + 1);
        for (int i = 0; i < chiplet_pkg::max_words; i++) begin
            words[i*chiplet_pkg::data_width +: chiplet_pkg::data_width] = rand_bits(32);
        end
    endtask

    task automatic send_local(input logic [1:0] dest, input logic [2:0] len,
                              input logic [words_width-1:0] words, output int first_stalls);
        if (dest != chiplet_pkg::node_id) begin
            expect_packet(chiplet_pkg::node_id, dest, len, words);
        end
        first_stalls = 0;
        for (int i = 0; i < int'(len); i++) begin
            write_reg(chiplet_pkg::reg_tx_data,
                      words[i*chiplet_pkg::data_width +: chiplet_pkg::data_width], '1, 1'b0);
            if (i == 0) begin
                first_stalls = last_stalls;
            end
        end
        write_reg(chiplet_pkg::reg_tx_send, 32'(dest), '1, 1'b0);
    endtask

    task automatic drive_ext(input logic [1:0] src, input logic [1:0] dest, input logic [2:0] len,
                             input logic [words_width-1:0] words);
        chiplet_pkg::flit_t f;
        for (int i = 0; i <= int'(len); i++) begin
            if (i == 0) begin
                f = head_flit(src, dest, len);
            end else begin
                f = data_flit(words[(i-1)*chiplet_pkg::data_width +: chiplet_pkg::data_width]);
            end
            in_flit = f;
            in_valid = 1'b1;
            @(negedge clk);
            while (!data_ready_in) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // poll status until a complete packet waits and then pop its words
    task automatic receive_packet(input logic [1:0] src, input logic [2:0] len,
                                  input logic [words_width-1:0] words);
        logic [31:0] st;
        logic [31:0] d;
        read_reg(chiplet_pkg::reg_status, 1'b0, st);
        while (!st[7]) begin
            read_reg(chiplet_pkg::reg_status, 1'b0, st);
        end
        check_word("status", status_word(3'd0, 1'b0, len, 1'b1, src), st);
        for (int i = 0; i < int'(len); i++) begin
            read_reg(chiplet_pkg::reg_rx_data, 1'b0, d);
            check_word("rdata", words[i*chiplet_pkg::data_width +: chiplet_pkg::data_width], d);
        end
    endtask

    task automatic wait_drained();
        while (exp_local.size() != 0 || exp_ext.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // random back-pressure on the external output
    initial begin
        bp_state = lfsr_seed;
        packet_sent = 1'b0;
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            #1;
            bp_state = lfsr_next(bp_state);
            packet_sent = bp_state[0];
        end
    end

    // compare each accepted output flit against the packet it belongs to
    always @(negedge clk) begin
        if (arst_n && data_ready_out && packet_sent) begin
            if (mon_left == 0) begin
                mon_from_ext = (out_flit.payload.head.source != chiplet_pkg::node_id);
            end
            if ((mon_from_ext && exp_ext.size() == 0) || (!mon_from_ext && exp_local.size() == 0)) begin
                $display("a flit left on out_flit although no packet was expected there");
                stop_on_failure();
            end else begin
                if (mon_from_ext) begin
                    mon_exp = exp_ext.pop_front();
                end else begin
                    mon_exp = exp_local.pop_front();
                end
                check_flit("out_flit", mon_exp, out_flit);
                if (mon_left == 0) begin
                    mon_left = int'(mon_exp.payload.head.length);
                end else begin
                    mon_left = mon_left - 1;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("the run hung and hit the limit of %0d cycles", timeout_cycles);
        stop_on_failure();
    end

    initial begin
        logic [31:0] d;
        logic [2:0] len;
        logic [1:0] dest;
        logic [1:0] src;
        logic [words_width-1:0] words;
        int stalls;

        wen = 1'b0;
        ren = 1'b0;
        addr = '0;
        wdata = '0;
        strobe = '0;
        in_flit = '0;
        in_valid = 1'b0;
        arst_n = 1'b0;
        mon_left = 0;
        mon_from_ext = 1'b0;
        lfsr_state = lfsr_seed;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        check_error("data_ready_out", 1'b0, data_ready_out);
        check_error("request_stall", 1'b0, request_stall);
        check_error("error", 1'b0, error);
        read_reg(chiplet_pkg::reg_node, 1'b0, d);
        check_word("rdata", 32'(chiplet_pkg::node_id), d);
        read_reg(chiplet_pkg::reg_status, 1'b0, d);
        check_word("rdata", 32'h0, d);

        write_reg(32'h2, 32'h1234, '1, 1'b1); // unaligned
        read_reg(32'h20, 1'b1, d); // unmapped
        read_reg(chiplet_pkg::reg_tx_data, 1'b1, d);
        write_reg(chiplet_pkg::reg_status, 32'h0, '1, 1'b1);
        write_reg(chiplet_pkg::reg_tx_data, rand_bits(32), 4'b0111, 1'b1);
        write_reg(chiplet_pkg::reg_tx_send, 32'h2, '1, 1'b1);
        read_reg(chiplet_pkg::reg_rx_data, 1'b1, d);
        read_reg(chiplet_pkg::reg_status, 1'b0, d);
        check_word("status", 32'h0, d);

        // fill the buffer so that a fifth push bounces
        for (int i = 0; i < chiplet_pkg::max_words; i++) begin
            words[i*chiplet_pkg::data_width +: chiplet_pkg::data_width] = rand_bits(32);
            write_reg(chiplet_pkg::reg_tx_data,
                      words[i*chiplet_pkg::data_width +: chiplet_pkg::data_width], '1, 1'b0);
        end
        write_reg(chiplet_pkg::reg_tx_data, rand_bits(32), '1, 1'b1);
        read_reg(chiplet_pkg::reg_status, 1'b0, d);
        check_word("status", status_word(3'd4, 1'b0, 3'd0, 1'b0, 2'd0), d);
        expect_packet(chiplet_pkg::node_id, 2'd2, 3'd4, words);
        write_reg(chiplet_pkg::reg_tx_send, 32'h2, '1, 1'b0);
        wait_drained();

        for (int k = 0; k < loop_packets; k++) begin
            random_packet(len, words);
            send_local(chiplet_pkg::node_id, len, words, stalls);
            receive_packet(chiplet_pkg::node_id, len, words);
        end

        for (int k = 0; k < out_packets; k++) begin
            random_packet(len, words);
            dest = other_node();
            send_local(dest, len, words, stalls);
            if (k > 0 && stalls == 0) begin
                $display("a push during transmission was accepted without a stall");
                stop_on_failure();
            end
        end
        wait_drained();

        for (int k = 0; k < in_packets; k++) begin
            random_packet(len, words);
            src = other_node();
            drive_ext(src, chiplet_pkg::node_id, len, words);
            receive_packet(src, len, words);
        end

        // external traffic competes with endpoint packets for the output
        for (int k = 0; k < pass_packets; k++) begin
            random_packet(ext_len[k], ext_words[k]);
            ext_src[k] = other_node();
            ext_dest[k] = other_node();
            expect_packet(ext_src[k], ext_dest[k], ext_len[k], ext_words[k]);
        end
        fork
            begin
                for (int k = 0; k < pass_packets; k++) begin
                    drive_ext(ext_src[k], ext_dest[k], ext_len[k], ext_words[k]);
                end
            end
            begin
                for (int k = 0; k < pass_packets; k++) begin
                    random_packet(len, words);
                    dest = other_node();
                    send_local(dest, len, words, stalls);
                end
            end
        join
        wait_drained();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/switch_endpoint_top.sv
`timescale 1ns/1ps
`default_nettype none

module switch_endpoint_top (
    input  logic clk,
    input  logic arst_n,
    input  logic wen,
    input  logic ren,
    input  logic [chiplet_pkg::addr_width-1:0] addr,
    input  logic [chiplet_pkg::data_width-1:0] wdata,
    input  logic [chiplet_pkg::strobe_width-1:0] strobe,
    output logic [chiplet_pkg::data_width-1:0] rdata,
    output logic error,
    output logic request_stall,
    input  chiplet_pkg::flit_t in_flit,
    input  logic in_valid,
    output logic data_ready_in,
    output chiplet_pkg::flit_t out_flit,
    output logic data_ready_out, // valid toward the external consumer
    input  logic packet_sent
);
    logic tx_push;
    logic [chiplet_pkg::data_width-1:0] tx_word;
    logic tx_send;
    logic [chiplet_pkg::node_width-1:0] tx_dest;
    logic [chiplet_pkg::count_width-1:0] tx_count;
    logic tx_busy;
    logic [chiplet_pkg::data_width-1:0] rx_word;
    logic [chiplet_pkg::count_width-1:0] rx_count;
    logic rx_valid;
    logic [chiplet_pkg::node_width-1:0] rx_source;
    logic rx_pop;
    chiplet_pkg::flit_t tx_flit;
    logic tx_flit_valid;
    logic tx_flit_ready;
    chiplet_pkg::flit_t rx_flit;
    logic rx_flit_valid;
    logic rx_flit_ready;

    endpoint_regs endpoint_regs_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wen(wen),
        .ren(ren),
        .addr(addr),
        .wdata(wdata),
        .strobe(strobe),
        .tx_count(tx_count),
        .tx_busy(tx_busy),
        .rx_word(rx_word),
        .rx_count(rx_count),
        .rx_valid(rx_valid),
        .rx_source(rx_source),
        .rdata(rdata),
        .error(error),
        .request_stall(request_stall),
        .tx_push(tx_push),
        .tx_word(tx_word),
        .tx_send(tx_send),
        .tx_dest(tx_dest),
        .rx_pop(rx_pop)
    );

    endpoint_tx endpoint_tx_inst (
        .clk(clk),
        .arst_n(arst_n),
        .tx_push(tx_push),
        .tx_word(tx_word),
        .tx_send(tx_send),
        .tx_dest(tx_dest),
        .flit_ready(tx_flit_ready),
        .flit(tx_flit),
        .flit_valid(tx_flit_valid),
        .tx_count(tx_count),
        .tx_busy(tx_busy)
    );

    endpoint_rx endpoint_rx_inst (
        .clk(clk),
        .arst_n(arst_n),
        .flit(rx_flit),
        .flit_valid(rx_flit_valid),
        .rx_pop(rx_pop),
        .flit_ready(rx_flit_ready),
        .rx_word(rx_word),
        .rx_count(rx_count),
        .rx_valid(rx_valid),
        .rx_source(rx_source)
    );

    switch_core switch_core_inst (
        .clk(clk),
        .arst_n(arst_n),
        .local_in_flit(tx_flit),
        .local_in_valid(tx_flit_valid),
        .ext_in_flit(in_flit),
        .ext_in_valid(in_valid),
        .local_out_ready(rx_flit_ready),
        .ext_out_ready(packet_sent),
        .local_in_ready(tx_flit_ready),
        .ext_in_ready(data_ready_in),
        .local_out_flit(rx_flit),
        .local_out_valid(rx_flit_valid),
        .ext_out_flit(out_flit),
        .ext_out_valid(data_ready_out)
    );

endmodule

`default_nettype wire

//--- hw/switch/switch_core.sv
`timescale 1ns/1ps
`default_nettype none

module switch_core (
    input  logic clk,
    input  logic arst_n,
    input  chiplet_pkg::flit_t local_in_flit,
    input  logic local_in_valid,
    input  chiplet_pkg::flit_t ext_in_flit,
    input  logic ext_in_valid,
    input  logic local_out_ready,
    input  logic ext_out_ready,
    output logic local_in_ready,
    output logic ext_in_ready,
    output chiplet_pkg::flit_t local_out_flit,
    output logic local_out_valid,
    output chiplet_pkg::flit_t ext_out_flit,
    output logic ext_out_valid
);
    // index 0 is the local port, 1 the external port
    chiplet_pkg::flit_t in_flit [2];
    chiplet_pkg::flit_t front [2];
    logic [1:0] in_valid;
    logic [1:0] in_ready;
    logic [1:0] empty;
    logic [1:0] front_port;
    logic [1:0] pop;
    logic [1:0] out_ready;

    assign in_flit[0] = local_in_flit;
    assign in_flit[1] = ext_in_flit;
    assign in_valid = {ext_in_valid, local_in_valid};
    assign local_in_ready = in_ready[0];
    assign ext_in_ready = in_ready[1];
    assign out_ready = {ext_out_ready, local_out_ready};

    for (genvar i = 0; i < 2; i++) begin : g_in
        chiplet_pkg::flit_t mem [chiplet_pkg::fifo_depth];
        logic [chiplet_pkg::fifo_ptr_width-1:0] wr_ptr;
        logic [chiplet_pkg::fifo_ptr_width-1:0] rd_ptr;
        logic [chiplet_pkg::fifo_ptr_width:0] cnt;
        logic push;

        assign push = in_valid[i] && in_ready[i];
        assign in_ready[i] = !cnt[chiplet_pkg::fifo_ptr_width]; // msb set means full
        assign empty[i] = (cnt == '0);
        assign front[i] = mem[rd_ptr];
        // route decision, only meaningful while a head sits at the front
        assign front_port[i] = (mem[rd_ptr].payload.head.dest != chiplet_pkg::node_id);

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= in_flit[i];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop[i]) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({push, pop[i]})
                    2'b10: cnt <= cnt + 1'b1;
                    2'b01: cnt <= cnt - 1'b1;
                    default: cnt <= cnt;
                endcase
            end
        end
    end

    for (genvar o = 0; o < 2; o++) begin : g_out
        chiplet_pkg::flit_t flit_q;
        logic valid_q;
        logic [1:0] req;
        logic [1:0] take;
        logic [chiplet_pkg::count_width-1:0] left_q; // data flits still owed
        logic busy_q; // packet in progress, owner locked
        logic owner_q;
        logic rr_q;
        logic pick;
        logic sel;
        logic can_load;
        logic start;
        logic cont;

        always_comb begin
            for (int i = 0; i < 2; i++) begin
                req[i] = !empty[i] && (front[i].kind == chiplet_pkg::head) &&
                    (front_port[i] == 1'(o));
            end
        end

        assign can_load = !valid_q || out_ready[o];
        assign pick = req[rr_q] ? rr_q : !rr_q;
        assign start = !busy_q && (req != 2'b00) && can_load;
        assign cont = busy_q && !empty[owner_q] && can_load;
        assign sel = busy_q ? owner_q : pick;
        assign take = (start || cont) ? (2'b01 << sel) : 2'b00;

        always_ff @(posedge clk) begin
            if (start || cont) begin
                flit_q <= front[sel];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= 1'b0;
                busy_q <= 1'b0;
                owner_q <= 1'b0;
                rr_q <= 1'b0;
                left_q <= '0;
            end else begin
                if (can_load) begin
                    valid_q <= start || cont;
                end
                if (start) begin
                    owner_q <= pick;
                    rr_q <= !pick; // other input goes first next time
                    busy_q <= (front[pick].payload.head.length != '0);
                    left_q <= front[pick].payload.head.length;
                end else if (cont) begin
                    left_q <= left_q - 1'b1;
                    if (left_q == 1) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    assign pop = g_out[0].take | g_out[1].take;
    assign local_out_flit = g_out[0].flit_q;
    assign local_out_valid = g_out[0].valid_q;
    assign ext_out_flit = g_out[1].flit_q;
    assign ext_out_valid = g_out[1].valid_q;

endmodule

`default_nettype wire

//--- hw/endpoint/endpoint_rx.sv
`timescale 1ns/1ps
`default_nettype none

module endpoint_rx (
    input  logic clk,
    input  logic arst_n,
    input  chiplet_pkg::flit_t flit,
    input  logic flit_valid,
    input  logic rx_pop,
    output logic flit_ready,
    output logic [chiplet_pkg::data_width-1:0] rx_word,
    output logic [chiplet_pkg::count_width-1:0] rx_count,
    output logic rx_valid,
    output logic [chiplet_pkg::node_width-1:0] rx_source
);
    logic [chiplet_pkg::data_width-1:0] words [chiplet_pkg::max_words];
    logic [chiplet_pkg::word_idx_width-1:0] wr_idx;
    logic [chiplet_pkg::word_idx_width-1:0] rd_idx;
    logic [chiplet_pkg::count_width-1:0] len_q;
    logic [chiplet_pkg::count_width-1:0] count_q;
    logic [chiplet_pkg::node_width-1:0] src_q;
    logic valid_q;
    logic accept;
    logic is_head;

    assign flit_ready = !valid_q; // hold off until software drains the packet
    assign accept = flit_valid && !valid_q;
    assign is_head = (flit.kind == chiplet_pkg::head);

    assign rx_word = words[rd_idx];
    assign rx_count = count_q;
    assign rx_valid = valid_q;
    assign rx_source = src_q;

    always_ff @(posedge clk) begin
        if (accept && !is_head) begin
            words[wr_idx] <= flit.payload.word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            len_q <= '0;
            count_q <= '0;
            src_q <= '0;
            valid_q <= 1'b0;
        end else begin
            if (accept && is_head) begin
                src_q <= flit.payload.head.source;
                len_q <= flit.payload.head.length;
                wr_idx <= '0;
            end else if (accept) begin
                wr_idx <= wr_idx + 1'b1;
                if ({1'b0, wr_idx} == len_q - 1'b1) begin
                    valid_q <= 1'b1;
                    count_q <= len_q;
                    rd_idx <= '0;
                end
            end
            if (rx_pop) begin
                rd_idx <= rd_idx + 1'b1;
                count_q <= count_q - 1'b1;
                if (count_q == 1) begin
                    valid_q <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/endpoint/endpoint_tx.sv
`timescale 1ns/1ps
`default_nettype none

module endpoint_tx (
    input  logic clk,
    input  logic arst_n,
    input  logic tx_push,
    input  logic [chiplet_pkg::data_width-1:0] tx_word,
    input  logic tx_send,
    input  logic [chiplet_pkg::node_width-1:0] tx_dest,
    input  logic flit_ready,
    output chiplet_pkg::flit_t flit,
    output logic flit_valid,
    output logic [chiplet_pkg::count_width-1:0] tx_count,
    output logic tx_busy
);
    logic [chiplet_pkg::data_width-1:0] words [chiplet_pkg::max_words];
    logic [chiplet_pkg::count_width-1:0] count_q;
    logic [chiplet_pkg::count_width-1:0] len_q;
    logic [chiplet_pkg::word_idx_width-1:0] idx_q;
    logic [chiplet_pkg::node_width-1:0] dest_q;
    logic busy_q;
    logic head_q; // head flit still to go
    logic accept;
    logic last;

    assign flit_valid = busy_q;
    assign tx_busy = busy_q;
    assign tx_count = count_q;
    assign accept = busy_q && flit_ready;
    assign last = !head_q && ({1'b0, idx_q} == len_q - 1'b1);

    always_comb begin
        flit = '0;
        flit.kind = head_q ? chiplet_pkg::head : chiplet_pkg::data;
        if (head_q) begin
            flit.payload.head.dest = dest_q;
            flit.payload.head.source = chiplet_pkg::node_id;
            flit.payload.head.length = len_q;
        end else begin
            flit.payload.word = words[idx_q];
        end
    end

    always_ff @(posedge clk) begin
        if (tx_push) begin
            words[count_q[chiplet_pkg::word_idx_width-1:0]] <= tx_word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            head_q <= 1'b0;
            count_q <= '0;
            len_q <= '0;
            idx_q <= '0;
            dest_q <= '0;
        end else begin
            if (tx_push) begin
                count_q <= count_q + 1'b1;
            end
            if (tx_send) begin
                busy_q <= 1'b1;
                head_q <= 1'b1;
                len_q <= count_q;
                dest_q <= tx_dest;
                idx_q <= '0;
            end else if (accept) begin
                if (head_q) begin
                    head_q <= 1'b0;
                end else if (last) begin
                    busy_q <= 1'b0;
                    count_q <= '0; // packet gone, buffer free again
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/endpoint/endpoint_regs.sv
`timescale 1ns/1ps
`default_nettype none

module endpoint_regs (
    input  logic clk,
    input  logic arst_n,
    input  logic wen,
    input  logic ren,
    input  logic [chiplet_pkg::addr_width-1:0] addr,
    input  logic [chiplet_pkg::data_width-1:0] wdata,
    input  logic [chiplet_pkg::strobe_width-1:0] strobe,
    input  logic [chiplet_pkg::count_width-1:0] tx_count,
    input  logic tx_busy,
    input  logic [chiplet_pkg::data_width-1:0] rx_word,
    input  logic [chiplet_pkg::count_width-1:0] rx_count,
    input  logic rx_valid,
    input  logic [chiplet_pkg::node_width-1:0] rx_source,
    output logic [chiplet_pkg::data_width-1:0] rdata,
    output logic error,
    output logic request_stall,
    output logic tx_push,
    output logic [chiplet_pkg::data_width-1:0] tx_word,
    output logic tx_send,
    output logic [chiplet_pkg::node_width-1:0] tx_dest,
    output logic rx_pop
);
    logic bad;
    logic done;
    logic busy;
    logic send_accept;
    logic send_q;
    logic [chiplet_pkg::node_width-1:0] dest_q;

    // send is issued one cycle after the bus write, so count that cycle as busy
    assign busy = tx_busy || send_q;

    assign request_stall = wen && busy &&
        (addr == chiplet_pkg::reg_tx_data || addr == chiplet_pkg::reg_tx_send);

    always_comb begin
        bad = 1'b0;
        if (wen) begin
            case (addr)
                chiplet_pkg::reg_tx_data: bad = (strobe != '1) ||
                    (tx_count == chiplet_pkg::count_width'(chiplet_pkg::max_words));
                chiplet_pkg::reg_tx_send: bad = (strobe != '1) || (tx_count == '0);
                default: bad = 1'b1; // unaligned, unmapped or read-only
            endcase
        end else if (ren) begin
            case (addr)
                chiplet_pkg::reg_rx_data: bad = !rx_valid || (rx_count == '0);
                chiplet_pkg::reg_status,
                chiplet_pkg::reg_node: bad = 1'b0;
                default: bad = 1'b1;
            endcase
        end
    end

    assign error = (wen || ren) && !request_stall && bad;
    assign done = (wen || ren) && !request_stall && !bad;

    assign tx_push = done && wen && (addr == chiplet_pkg::reg_tx_data);
    assign tx_word = wdata;
    assign send_accept = done && wen && (addr == chiplet_pkg::reg_tx_send);
    assign rx_pop = done && ren && (addr == chiplet_pkg::reg_rx_data);

    assign tx_send = send_q;
    assign tx_dest = dest_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            send_q <= 1'b0;
        end else begin
            send_q <= send_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (send_accept) begin
            dest_q <= wdata[chiplet_pkg::node_width-1:0];
        end
    end

    always_comb begin
        rdata = '0;
        if (ren && !bad) begin
            case (addr)
                chiplet_pkg::reg_rx_data: rdata = rx_word;
                chiplet_pkg::reg_status: begin
                    rdata[2:0] = tx_count;
                    rdata[3] = busy;
                    rdata[6:4] = rx_count;
                    rdata[7] = rx_valid;
                    rdata[9:8] = rx_source;
                end
                chiplet_pkg::reg_node: rdata[1:0] = chiplet_pkg::node_id;
                default: rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/chiplet_pkg.sv
`default_nettype none

package chiplet_pkg;

    // bus
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strobe_width = 4;

    // network
    localparam int total_nodes = 4;
    localparam int node_width = $clog2(total_nodes);
    localparam logic [node_width-1:0] node_id = 2'd1;
    localparam int max_words = 4;
    localparam int count_width = $clog2(max_words + 1);
    localparam int word_idx_width = $clog2(max_words);
    localparam int fifo_depth = 8; // must stay a power of two
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    // register map, byte offsets
    localparam logic [addr_width-1:0] reg_tx_data = 32'h00;
    localparam logic [addr_width-1:0] reg_tx_send = 32'h04;
    localparam logic [addr_width-1:0] reg_rx_data = 32'h08;
    localparam logic [addr_width-1:0] reg_status = 32'h0c;
    localparam logic [addr_width-1:0] reg_node = 32'h10;

    typedef enum logic {
        head,
        data
    } flit_kind_e;

    typedef struct packed {
        logic [data_width-count_width-2*node_width-1:0] reserved;
        logic [count_width-1:0] length; // data words that follow, 1 to 4
        logic [node_width-1:0] source;
        logic [node_width-1:0] dest;
    } head_t;

    typedef union packed {
        head_t head;
        logic [data_width-1:0] word;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_e kind;
        flit_payload_u payload;
    } flit_t;

endpackage

`default_nettype wire
